//--- include/ising_defs.svh
/* spin count, weight and field widths,
   and the register address map. */

`ifndef ISING_DEFS_SVH
`define ISING_DEFS_SVH

// machine size.
`define ISING_N             8
`define ISING_IDX_W         3

// signed weight and local-field widths.
`define WEIGHT_W            4
`define FIELD_W             8

// spin i reads at base + 4*i.
`define PHASE_ADDR_BASE     32'h0000_1000

// w[i][j] sits at base + 4*(i*N + j).
`define WEIGHT_ADDR_BASE    32'h0100_0000

`define CTR_CUTOFF_ADDR     32'h0000_0010
`define CTR_MAX_ADDR        32'h0000_0014
`define START_ADDR          32'h0000_0018
`define STATUS_ADDR         32'h0000_001C

// returned for any address outside the map.
`define UNMAPPED_DATA       32'hAAAA_AAAA

`endif

//--- logic/ising_pkg.sv
/* vector typedefs, anneal state enum,
   weight write and anneal config structs. */

`default_nettype none

`include "ising_defs.svh"

package ising_pkg;

    typedef logic [31:0]                    reg_word_t;
    typedef logic [`ISING_IDX_W-1:0]        spin_idx_t;
    typedef logic [`ISING_N-1:0]            spin_vec_t;
    typedef logic signed [`WEIGHT_W-1:0]    weight_t;
    typedef weight_t [`ISING_N-1:0]         weight_row_t;
    typedef logic signed [`FIELD_W-1:0]     field_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HOLD,
        ST_ANNEAL,
        ST_DONE
    } anneal_state_e;

    // single weight write from the host.
    typedef struct packed {
        logic      en;
        spin_idx_t row;
        spin_idx_t col;
        weight_t   value;
    } weight_wr_t;

    typedef struct packed {
        reg_word_t cutoff;
        reg_word_t max;
    } anneal_cfg_t;

endpackage

`default_nettype wire

//--- logic/ising_weight_ram.sv
/* N x N weight store in flops, with a full-row read
   for the update logic and a single-weight host read. */

`timescale 1ns/1ps
`default_nettype none

`include "ising_defs.svh"

module ising_weight_ram (
    input  wire                        clk,
    input  wire                        axi_rstn,
    input  wire ising_pkg::weight_wr_t wwr,
    input  wire ising_pkg::spin_idx_t  upd_row,
    input  wire ising_pkg::reg_word_t  rd_addr,
    output ising_pkg::weight_row_t     row,
    output ising_pkg::reg_word_t       weight_rdata
);
    import ising_pkg::*;

    weight_row_t mem [`ISING_N];

    reg_word_t   rd_off;
    spin_idx_t   rd_r;
    spin_idx_t   rd_c;
    weight_t     rd_w;

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            for (int i = 0; i < `ISING_N; i++) begin
                mem[i] <= '0;
            end
        end else if (wwr.en) begin
            mem[wwr.row][wwr.col] <= wwr.value;
        end
    end

    // row of the spin being updated.
    assign row = mem[upd_row];

    // host read splits the word offset into row and column.
    assign rd_off = (rd_addr - `WEIGHT_ADDR_BASE) >> 2;
    assign rd_r   = spin_idx_t'(rd_off / `ISING_N);
    assign rd_c   = spin_idx_t'(rd_off % `ISING_N);
    assign rd_w   = mem[rd_r][rd_c];

    assign weight_rdata = {{(32 - `WEIGHT_W){rd_w[`WEIGHT_W-1]}}, rd_w};

endmodule

`default_nettype wire

//--- logic/ising_anneal_ctrl.sv
/* anneal controller: cycle counter, phase decode
   and the update/done level outputs. */

`timescale 1ns/1ps
`default_nettype none

module ising_anneal_ctrl (
    input  wire                         clk,
    input  wire                         ising_rstn,
    input  wire ising_pkg::anneal_cfg_t cfg,
    output logic                        update_en,
    output logic                        done
);
    import ising_pkg::*;

    reg_word_t     cnt;
    anneal_state_e state;

    // phase from counter against the two bounds.
    always_comb begin
        if (!ising_rstn) begin
            state = ST_IDLE;
        end else if (cnt == cfg.max) begin
            state = ST_DONE;
        end else if (cnt >= cfg.cutoff) begin
            state = ST_ANNEAL;
        end else begin
            state = ST_HOLD;
        end
    end

    // counter saturates at max, so it never wraps.
    always_ff @(posedge clk) begin
        if (!ising_rstn) begin
            cnt <= '0;
        end else if (state != ST_DONE) begin
            cnt <= cnt + 32'd1;
        end
    end

    assign update_en = (state == ST_ANNEAL);
    assign done      = (state == ST_DONE);

    // done is sticky and blocks further updates until restart.
    a_done_sticky : assert property (@(posedge clk) disable iff (!ising_rstn)
        done |=> done && !update_en);

endmodule

`default_nettype wire

//--- logic/ising_spin_array.sv
/* spin register, round-robin update index,
   local-field adder and sign update rule. */

`timescale 1ns/1ps
`default_nettype none

`include "ising_defs.svh"

module ising_spin_array (
    input  wire                         clk,
    input  wire                         ising_rstn,
    input  wire                         update_en,
    input  wire ising_pkg::weight_row_t row,
    output ising_pkg::spin_idx_t        upd_row,
    output ising_pkg::spin_vec_t        phase
);
    import ising_pkg::*;

    field_t field;

    // sum of w[i][j] * s_j with s_j = +1 or -1.
    always_comb begin : field_sum
        weight_t w;
        field = '0;
        for (int j = 0; j < `ISING_N; j++) begin
            w = row[j];
            if (phase[j]) begin
                field = field + field_t'(w);
            end else begin
                field = field - field_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ising_rstn) begin
            phase   <= '0;
            upd_row <= '0;
        end else if (update_en) begin
            // zero field keeps the spin.
            if (field > 0) begin
                phase[upd_row] <= 1'b1;
            end else if (field < 0) begin
                phase[upd_row] <= 1'b0;
            end
            if (upd_row == spin_idx_t'(`ISING_N - 1)) begin
                upd_row <= '0;
            end else begin
                upd_row <= upd_row + spin_idx_t'(1);
            end
        end
    end

    // spins only move on controller-enabled cycles.
    a_phase_hold : assert property (@(posedge clk) disable iff (!ising_rstn)
        !update_en |=> $stable(phase));

endmodule

`default_nettype wire

//--- logic/top_ising.sv
/* Ising core: weight store, anneal controller
   and spin array. */

`timescale 1ns/1ps
`default_nettype none

module top_ising (
    input  wire                         clk,
    input  wire                         axi_rstn,
    input  wire                         ising_rstn,
    input  wire ising_pkg::anneal_cfg_t cfg,
    input  wire ising_pkg::weight_wr_t  wwr,
    input  wire ising_pkg::reg_word_t   rd_addr,
    output ising_pkg::spin_vec_t        phase,
    output logic                        done,
    output ising_pkg::reg_word_t        weight_rdata
);
    import ising_pkg::*;

    weight_row_t row;
    spin_idx_t   upd_row;
    logic        update_en;

    ising_weight_ram u_weight_ram (
        .clk          (clk),
        .axi_rstn     (axi_rstn),
        .wwr          (wwr),
        .upd_row      (upd_row),
        .rd_addr      (rd_addr),
        .row          (row),
        .weight_rdata (weight_rdata)
    );

    ising_anneal_ctrl u_anneal_ctrl (
        .clk        (clk),
        .ising_rstn (ising_rstn),
        .cfg        (cfg),
        .update_en  (update_en),
        .done       (done)
    );

    ising_spin_array u_spin_array (
        .clk        (clk),
        .ising_rstn (ising_rstn),
        .update_en  (update_en),
        .row        (row),
        .upd_row    (upd_row),
        .phase      (phase)
    );

endmodule

`default_nettype wire

//--- logic/ising_axi.sv
/* register wrapper: write decode, configuration registers,
   read data path and the Ising core. */

`timescale 1ns/1ps
`default_nettype none

`include "ising_defs.svh"

module ising_axi (
    input  wire                       clk,
    input  wire                       axi_rstn,
    input  wire                       arvalid_q,
    input  wire ising_pkg::reg_word_t araddr_q,
    input  wire                       rready,
    output logic                      rvalid,
    output logic                      rresp,
    output ising_pkg::reg_word_t      rdata,
    input  wire                       wready,
    input  wire ising_pkg::reg_word_t wr_addr,
    input  wire ising_pkg::reg_word_t wdata
);
    import ising_pkg::*;

    anneal_cfg_t cfg;
    logic        ising_rstn;
    weight_wr_t  wwr;
    reg_word_t   w_off;
    spin_vec_t   phase;
    logic        done;
    reg_word_t   weight_rdata;
    spin_idx_t   phase_idx;
    logic        phase_sel;
    logic        weight_sel;
    reg_word_t   rd_mux;

    // weight writes go straight to the store.
    assign w_off     = (wr_addr - `WEIGHT_ADDR_BASE) >> 2;
    assign wwr.en    = wready && (wr_addr >= `WEIGHT_ADDR_BASE)
                     && (wr_addr < `WEIGHT_ADDR_BASE + 4 * `ISING_N * `ISING_N);
    assign wwr.row   = spin_idx_t'(w_off / `ISING_N);
    assign wwr.col   = spin_idx_t'(w_off % `ISING_N);
    assign wwr.value = wdata[`WEIGHT_W-1:0];

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            cfg        <= '0;
            ising_rstn <= 1'b0;
        end else if (wready) begin
            if (wr_addr == `CTR_CUTOFF_ADDR) begin
                cfg.cutoff <= wdata;
            end
            if (wr_addr == `CTR_MAX_ADDR) begin
                cfg.max <= wdata;
            end
            if (wr_addr == `START_ADDR) begin
                ising_rstn <= wdata[0];
            end
        end
    end

    // read select.
    assign phase_idx  = spin_idx_t'((araddr_q - `PHASE_ADDR_BASE) >> 2);
    assign phase_sel  = (araddr_q >= `PHASE_ADDR_BASE)
                      && (araddr_q < `PHASE_ADDR_BASE + 4 * `ISING_N);
    assign weight_sel = (araddr_q >= `WEIGHT_ADDR_BASE)
                      && (araddr_q < `WEIGHT_ADDR_BASE + 4 * `ISING_N * `ISING_N);

    always_comb begin
        if (phase_sel) begin
            rd_mux = {31'b0, phase[phase_idx]};
        end else if (weight_sel) begin
            rd_mux = weight_rdata;
        end else if (araddr_q == `STATUS_ADDR) begin
            rd_mux = {31'b0, done};
        end else begin
            rd_mux = `UNMAPPED_DATA;
        end
    end

    // held rvalid is the only back-pressure.
    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else if (arvalid_q && !rvalid) begin
            rvalid <= 1'b1;
            rdata  <= rd_mux;
        end
    end

    assign rresp = 1'b0;

    top_ising u_top_ising (
        .clk          (clk),
        .axi_rstn     (axi_rstn),
        .ising_rstn   (ising_rstn),
        .cfg          (cfg),
        .wwr          (wwr),
        .rd_addr      (araddr_q),
        .phase        (phase),
        .done         (done),
        .weight_rdata (weight_rdata)
    );

    // read response held with stable data until taken.
    a_rvalid_hold : assert property (@(posedge clk) disable iff (!axi_rstn)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- tb/tb_ising_axi.sv
/* testbench for the Ising register wrapper with bus tasks,
   a software model of the spin update and directed tests. */

`timescale 1ns/1ps
`default_nettype none

`include "ising_defs.svh"

module tb_ising_axi;
    import ising_pkg::*;

    localparam int N = `ISING_N;
    // two weight loads, one readback and the status polls take about 1k cycles.
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk;
    logic      axi_rstn;
    logic      arvalid_q;
    reg_word_t araddr_q;
    logic      rready;
    logic      wready;
    reg_word_t wr_addr;
    reg_word_t wdata;
    logic      rvalid;
    logic      rresp;
    reg_word_t rdata;

    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    int        seed;
    int        wgt [N][N];
    spin_vec_t model_phase;

    ising_axi dut_i (
        .clk       (clk),
        .axi_rstn  (axi_rstn),
        .arvalid_q (arvalid_q),
        .araddr_q  (araddr_q),
        .rready    (rready),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .rdata     (rdata),
        .wready    (wready),
        .wr_addr   (wr_addr),
        .wdata     (wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped: no result after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input reg_word_t exp, input reg_word_t got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    function automatic reg_word_t weight_addr(input int i, input int j);
        return `WEIGHT_ADDR_BASE + reg_word_t'(4 * (i * N + j));
    endfunction

    function automatic reg_word_t phase_addr(input int i);
        return `PHASE_ADDR_BASE + reg_word_t'(4 * i);
    endfunction

    task automatic bus_write(input reg_word_t addr, input reg_word_t data);
        @(posedge clk);
        wready  <= 1'b1;
        wr_addr <= addr;
        wdata   <= data;
        @(posedge clk);
        wready  <= 1'b0;
    endtask

    task automatic bus_read(input reg_word_t addr, output reg_word_t data);
        @(posedge clk);
        arvalid_q <= 1'b1;
        araddr_q  <= addr;
        @(posedge clk);
        arvalid_q <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // random weights in the signed 4-bit range.
    task automatic load_weights();
        logic [31:0] r;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                r = $random(seed);
                wgt[i][j] = int'(weight_t'(r[`WEIGHT_W-1:0]));
                bus_write(weight_addr(i, j), reg_word_t'(wgt[i][j]));
            end
        end
    endtask

    task automatic verify_weights(input string name);
        reg_word_t v;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                bus_read(weight_addr(i, j), v);
                check_word(name, reg_word_t'(wgt[i][j]), v);
            end
        end
    endtask

    task automatic verify_phases(input string name, input spin_vec_t exp);
        reg_word_t v;
        for (int i = 0; i < N; i++) begin
            bus_read(phase_addr(i), v);
            check_word(name, reg_word_t'(exp[i]), v);
        end
    endtask

    task automatic wait_done();
        reg_word_t v;
        do begin
            bus_read(`STATUS_ADDR, v);
        end while (v[0] !== 1'b1);
    endtask

    // round-robin sign rule with one spin per update.
    task automatic model_anneal(input int cutoff, input int max_cnt);
        int updates;
        int idx;
        int field;
        model_phase = '0;
        updates = (max_cnt > cutoff) ? max_cnt - cutoff : 0;
        idx = 0;
        for (int k = 0; k < updates; k++) begin
            field = 0;
            for (int j = 0; j < N; j++) begin
                field = field + (model_phase[j] ? wgt[idx][j] : -wgt[idx][j]);
            end
            if (field > 0) begin
                model_phase[idx] = 1'b1;
            end else if (field < 0) begin
                model_phase[idx] = 1'b0;
            end
            idx = (idx + 1) % N;
        end
    endtask

    task automatic reset_reads();
        reg_word_t v;
        verify_phases("reset phase", '0);
        bus_read(`STATUS_ADDR, v);
        check_word("reset status", 32'h0, v);
        check_word("reset rresp", 32'h0, reg_word_t'(rresp));
        bus_read(32'h0000_0000, v);
        check_word("unmapped zero", `UNMAPPED_DATA, v);
        bus_read(phase_addr(N), v);
        check_word("unmapped phase end", `UNMAPPED_DATA, v);
        bus_read(32'h0200_0000, v);
        check_word("unmapped high", `UNMAPPED_DATA, v);
    endtask

    task automatic weight_readback();
        load_weights();
        verify_weights("weight readback");
    endtask

    task automatic hold_phase();
        bus_write(`CTR_CUTOFF_ADDR, 32'd10);
        bus_write(`CTR_MAX_ADDR, 32'd10);
        bus_write(`START_ADDR, 32'd1);
        wait_done();
        verify_phases("hold phase", '0);
        bus_write(`START_ADDR, 32'd0);
    endtask

    task automatic anneal_run(input string name);
        bus_write(`CTR_CUTOFF_ADDR, 32'd5);
        bus_write(`CTR_MAX_ADDR, reg_word_t'(5 + 3 * N));
        model_anneal(5, 5 + 3 * N);
        bus_write(`START_ADDR, 32'd1);
        wait_done();
        verify_phases(name, model_phase);
    endtask

    task automatic restart_run();
        reg_word_t v;
        bus_write(`START_ADDR, 32'd0);
        bus_read(`STATUS_ADDR, v);
        check_word("restart status", 32'h0, v);
        verify_phases("restart cleared", '0);
        load_weights();
        anneal_run("restart anneal");
    endtask

    // rready held off while a second request to an unmapped address is offered.
    task automatic read_backpressure();
        reg_word_t exp;
        reg_word_t first;
        exp = reg_word_t'(wgt[2][5]);
        @(posedge clk);
        arvalid_q <= 1'b1;
        araddr_q  <= weight_addr(2, 5);
        @(posedge clk);
        arvalid_q <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        first = rdata;
        check_word("backpressure data", exp, first);
        for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            arvalid_q <= (k == 2);
            araddr_q  <= 32'h0000_0000;
            @(negedge clk);
            check_word("backpressure rvalid", 32'h1, reg_word_t'(rvalid));
            check_word("backpressure hold", exp, rdata);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        check_word("backpressure release", 32'h0, reg_word_t'(rvalid));
    endtask

    initial begin
        axi_rstn  = 1'b0;
        arvalid_q = 1'b0;
        araddr_q  = '0;
        rready    = 1'b0;
        wready    = 1'b0;
        wr_addr   = '0;
        wdata     = '0;
        seed      = 32'h27c3;
        repeat (3) @(posedge clk);
        axi_rstn <= 1'b1;

        reset_reads();
        weight_readback();
        hold_phase();
        anneal_run("anneal");
        restart_run();
        read_backpressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ising_axi.f
+incdir+include
logic/ising_pkg.sv
logic/ising_weight_ram.sv
logic/ising_anneal_ctrl.sv
logic/ising_spin_array.sv
logic/top_ising.sv
logic/ising_axi.sv
tb/tb_ising_axi.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the Ising register wrapper testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f ising_axi.f \
    --top-module tb_ising_axi -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
    exit 0
fi
exit 1
